// ==== rtl/fix_defines.svh ====
// size macros shared by the fix checksum engine.
// lane count, session id width and statistics counter width.

`ifndef FIX_DEFINES_SVH
`define FIX_DEFINES_SVH

// one checksum lane per trading session.
`define FIX_NUM_LANES 4

// session id carried next to every stream byte.
`define FIX_SID_W 2

// good and bad message counters, saturating.
`define FIX_CNT_W 16

// lane count and sid width must agree, 2**FIX_SID_W lanes.
// counters wide enough for long soak runs.

`endif

// ==== rtl/fix_proto_pkg.sv ====
// fix protocol types and ascii constants.
// stream byte, three-digit checksum field, separator and tag characters.

package fix_proto_pkg;

	// one byte of the fix stream.
	typedef logic [7:0] fix_byte_t;

	// checksum field as three ascii digits, hundreds in the top byte.
	typedef logic [23:0] fix_ascii3_t;

	// field separator, ctrl-a.
	localparam fix_byte_t FIX_SOH = 8'h01;

	// characters of the "10=" trailer tag.
	localparam fix_byte_t FIX_CHAR_ONE = 8'h31; // '1'.
	localparam fix_byte_t FIX_CHAR_ZERO = 8'h30; // '0'.
	localparam fix_byte_t FIX_CHAR_EQ = 8'h3d; // '='.

	// base for binary to ascii digit conversion.
	localparam fix_byte_t FIX_CHAR_DIGIT0 = 8'h30;

	// digits after the tag are always three wide, zero padded.
	// e.g. sum 7 is sent as "007".

endpackage

// ==== rtl/fix_engine_pkg.sv ====
// engine types for the checksum datapath.
// session id, statistics counter and lane parser states.

`include "fix_defines.svh"

package fix_engine_pkg;

	// session number, also the lane index.
	typedef logic [`FIX_SID_W-1:0] sid_t;

	// message statistics counter.
	typedef logic [`FIX_CNT_W-1:0] stat_cnt_t;

	// trailer parser states of a lane.
	typedef enum logic [2:0] {
		BODY   = 3'd0, // inside a field.
		SEP    = 3'd1, // last byte was soh.
		TAG1   = 3'd2, // soh then '1'.
		TAG0   = 3'd3, // soh then "10".
		DIGITS = 3'd4, // after "10=", collecting digits.
		DONE   = 3'd5  // trailer soh seen.
	} lane_state_e;

endpackage

// ==== rtl/fix_session_demux.sv ====
// session demultiplexer for the interleaved fix stream.
// per-session open tracking, one-hot lane strobes and sequence errors.
`timescale 1ns/1ps

`include "fix_defines.svh"

module fix_session_demux
	import fix_proto_pkg::*;
	import fix_engine_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  fix_byte_t                 byte_i,
	input  logic                      byte_valid_i,
	input  logic                      sof_i,
	input  logic                      eof_i,
	input  sid_t                      sid_i,
	output fix_byte_t                 lane_byte_o,
	output logic [`FIX_NUM_LANES-1:0] lane_valid_o,
	output logic [`FIX_NUM_LANES-1:0] lane_sof_o,
	output logic [`FIX_NUM_LANES-1:0] lane_eof_o,
	output logic                      seq_err_o
);

	logic [`FIX_NUM_LANES-1:0] sid_hot; // decoded session.
	logic [`FIX_NUM_LANES-1:0] open_q; // message open per session.
	logic is_open, accept, orphan, restart;

	always_comb begin
		for (int i = 0; i < `FIX_NUM_LANES; i++) begin
			sid_hot[i] = (sid_i == sid_t'(i));
		end
		is_open = open_q[sid_i];
		accept = byte_valid_i && (sof_i || is_open); // sof always opens.
		orphan = byte_valid_i && !sof_i && !is_open; // byte with no message, dropped.
		restart = byte_valid_i && sof_i && is_open; // old message abandoned.
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			open_q <= '0;
			lane_valid_o <= '0;
			lane_sof_o <= '0;
			lane_eof_o <= '0;
			seq_err_o <= 1'b0;
		end else begin
			if (accept && eof_i) open_q <= open_q & ~sid_hot; // eof wins over sof.
			else if (accept && sof_i) open_q <= open_q | sid_hot;
			lane_valid_o <= accept ? sid_hot : '0;
			lane_sof_o <= (accept && sof_i) ? sid_hot : '0;
			lane_eof_o <= (accept && eof_i) ? sid_hot : '0;
			seq_err_o <= orphan || restart;
		end
	end

	always_ff @(posedge clk) begin
		lane_byte_o <= byte_i; // broadcast, qualified by lane_valid_o.
	end

	// only one lane can be fed per cycle.
	a_lane_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(lane_valid_o));

endmodule

// ==== rtl/fix_checksum_lane.sv ====
// per-session fix checksum lane.
// trailer parser, modulo-256 summer, ascii conversion and digit compare.
`timescale 1ns/1ps

module fix_checksum_lane
	import fix_proto_pkg::*;
	import fix_engine_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  fix_byte_t   byte_i,
	input  logic        valid_i,
	input  logic        sof_i,
	input  logic        eof_i,
	output logic        res_valid_o,
	output fix_byte_t   sum_o,
	output fix_ascii3_t calc_ascii_o,
	output fix_ascii3_t rcv_ascii_o,
	output logic        match_o,
	output logic        frame_err_o
);

	lane_state_e state_q, state_d;
	lane_state_e base_state; // state seen by this byte, body on sof.
	fix_byte_t sum_q; // running sum of the message.
	fix_byte_t soh_sum_q; // sum through the latest soh.
	fix_byte_t frz_sum_q; // sum frozen at the trailer '='.
	fix_byte_t base_sum;
	fix_byte_t new_sum;
	fix_ascii3_t rcv_q; // received trailer digits.
	logic [1:0] dcnt_q; // digits collected, 0..3.
	logic dbad_q; // non-digit or fourth digit seen.
	logic is_soh, is_digit, tag_eq, trailer_ok;

	// eof stage.
	logic s1_valid_q;
	logic s1_ok_q;
	fix_byte_t s1_sum_q;
	fix_ascii3_t s1_rcv_q;

	// conversion stage.
	fix_byte_t hund, tens, ones;
	fix_ascii3_t calc_ascii;

	always_comb begin
		is_soh = (byte_i == FIX_SOH);
		is_digit = (byte_i >= FIX_CHAR_DIGIT0) && (byte_i <= FIX_CHAR_DIGIT0 + 8'd9);
		base_state = sof_i ? BODY : state_q; // a new sof restarts parsing.
		base_sum = sof_i ? '0 : sum_q;
		new_sum = base_sum + byte_i; // wraps modulo 256.
		tag_eq = (base_state == TAG0) && (byte_i == FIX_CHAR_EQ);
		// eof byte must be the soh right after exactly three clean digits.
		trailer_ok = (base_state == DIGITS) && is_soh && (dcnt_q == 2'd3) && !dbad_q;
	end

	// trailer tag parser, soh '1' '0' '='.
	always_comb begin
		state_d = base_state;
		case (base_state)
			BODY: begin
				if (is_soh) state_d = SEP;
			end
			SEP, DONE: begin
				if (is_soh) state_d = SEP;
				else if (byte_i == FIX_CHAR_ONE) state_d = TAG1;
				else state_d = BODY;
			end
			TAG1: begin
				if (byte_i == FIX_CHAR_ZERO) state_d = TAG0;
				else state_d = is_soh ? SEP : BODY;
			end
			TAG0: begin
				if (byte_i == FIX_CHAR_EQ) state_d = DIGITS;
				else state_d = is_soh ? SEP : BODY;
			end
			DIGITS: begin
				if (is_soh) state_d = DONE; // trailer value ends.
			end
			default: state_d = BODY;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= BODY;
			dcnt_q <= 2'd0;
			dbad_q <= 1'b0;
		end else if (valid_i) begin
			state_q <= state_d;
			if (tag_eq) begin
				dcnt_q <= 2'd0; // fresh trailer value.
				dbad_q <= 1'b0;
			end else if (base_state == DIGITS && !is_soh) begin
				if (is_digit && dcnt_q != 2'd3) dcnt_q <= dcnt_q + 2'd1;
				else dbad_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			sum_q <= new_sum;
			if (is_soh) soh_sum_q <= new_sum; // soh itself is in the sum.
			if (tag_eq) begin
				frz_sum_q <= soh_sum_q; // covers up to the soh before "10=".
				rcv_q <= '0;
			end else if (base_state == DIGITS && !is_soh && is_digit && dcnt_q != 2'd3) begin
				rcv_q <= {rcv_q[15:0], byte_i}; // shift in, first digit ends on top.
			end
		end
	end

	// eof stage, capture the frozen sum and the received field.
	always_ff @(posedge clk) begin
		if (rst) s1_valid_q <= 1'b0;
		else s1_valid_q <= valid_i && eof_i;
	end

	always_ff @(posedge clk) begin
		if (valid_i && eof_i) begin
			s1_sum_q <= frz_sum_q;
			s1_rcv_q <= rcv_q;
			s1_ok_q <= trailer_ok;
		end
	end

	// binary to three ascii digits.
	always_comb begin
		hund = s1_sum_q / 8'd100;
		tens = (s1_sum_q % 8'd100) / 8'd10;
		ones = s1_sum_q % 8'd10;
		calc_ascii = {fix_byte_t'(FIX_CHAR_DIGIT0 + hund),
			fix_byte_t'(FIX_CHAR_DIGIT0 + tens),
			fix_byte_t'(FIX_CHAR_DIGIT0 + ones)};
	end

	always_ff @(posedge clk) begin
		if (rst) res_valid_o <= 1'b0;
		else res_valid_o <= s1_valid_q;
	end

	always_ff @(posedge clk) begin
		if (s1_valid_q) begin
			sum_o <= s1_sum_q;
			calc_ascii_o <= calc_ascii;
			rcv_ascii_o <= s1_rcv_q;
			match_o <= s1_ok_q && (calc_ascii == s1_rcv_q); // no match on frame error.
			frame_err_o <= !s1_ok_q;
		end
	end

	// one result per message, never back to back.
	a_res_single: assert property (@(posedge clk) disable iff (rst)
		res_valid_o |=> !res_valid_o);

endmodule

// ==== rtl/fix_result_merge.sv ====
// merge of lane results onto one output.
// lane select, session encode and saturating good and bad counters.
`timescale 1ns/1ps

`include "fix_defines.svh"

module fix_result_merge
	import fix_proto_pkg::*;
	import fix_engine_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic [`FIX_NUM_LANES-1:0]    lane_res_valid_i,
	input  logic [`FIX_NUM_LANES*8-1:0]  lane_sum_i,
	input  logic [`FIX_NUM_LANES*24-1:0] lane_calc_i,
	input  logic [`FIX_NUM_LANES*24-1:0] lane_rcv_i,
	input  logic [`FIX_NUM_LANES-1:0]    lane_match_i,
	input  logic [`FIX_NUM_LANES-1:0]    lane_ferr_i,
	output logic                         result_valid_o,
	output sid_t                         result_sid_o,
	output fix_byte_t                    checksum_o,
	output fix_ascii3_t                  checksum_ascii_o,
	output fix_ascii3_t                  rcv_ascii_o,
	output logic                         match_o,
	output logic                         frame_err_o,
	output stat_cnt_t                    good_cnt_o,
	output stat_cnt_t                    bad_cnt_o
);

	logic any_valid;
	sid_t sel_sid; // index of the finishing lane.
	fix_byte_t sel_sum;
	fix_ascii3_t sel_calc, sel_rcv;
	logic sel_match, sel_ferr;

	always_comb begin
		any_valid = |lane_res_valid_i;
		sel_sid = '0;
		sel_sum = '0;
		sel_calc = '0;
		sel_rcv = '0;
		sel_match = 1'b0;
		sel_ferr = 1'b0;
		for (int i = 0; i < `FIX_NUM_LANES; i++) begin
			if (lane_res_valid_i[i]) begin
				sel_sid = sid_t'(i); // lane index is the session.
				sel_sum = lane_sum_i[i*8 +: 8];
				sel_calc = lane_calc_i[i*24 +: 24];
				sel_rcv = lane_rcv_i[i*24 +: 24];
				sel_match = lane_match_i[i];
				sel_ferr = lane_ferr_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid_o <= 1'b0;
			good_cnt_o <= '0;
			bad_cnt_o <= '0;
		end else begin
			result_valid_o <= any_valid;
			if (any_valid) begin
				if (sel_match) begin
					if (good_cnt_o != '1) good_cnt_o <= good_cnt_o + 1'b1; // hold at max.
				end else begin
					if (bad_cnt_o != '1) bad_cnt_o <= bad_cnt_o + 1'b1; // mismatch or frame error.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (any_valid) begin
			result_sid_o <= sel_sid;
			checksum_o <= sel_sum;
			checksum_ascii_o <= sel_calc;
			rcv_ascii_o <= sel_rcv;
			match_o <= sel_match;
			frame_err_o <= sel_ferr;
		end
	end

	// single byte per cycle and fixed latency keep lanes apart.
	a_one_lane: assert property (@(posedge clk) disable iff (rst)
		$onehot0(lane_res_valid_i));

endmodule

// ==== rtl/fix_checksum_top.sv ====
// top level of the fix checksum engine.
// session demux, generated checksum lanes and result merge.
`timescale 1ns/1ps

`include "fix_defines.svh"

module fix_checksum_top
	import fix_proto_pkg::*;
	import fix_engine_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  fix_byte_t   byte_i,
	input  logic        byte_valid_i,
	input  logic        sof_i,
	input  logic        eof_i,
	input  sid_t        sid_i,
	output logic        result_valid_o,
	output sid_t        result_sid_o,
	output fix_byte_t   checksum_o,
	output fix_ascii3_t checksum_ascii_o,
	output fix_ascii3_t rcv_ascii_o,
	output logic        match_o,
	output logic        frame_err_o,
	output stat_cnt_t   good_cnt_o,
	output stat_cnt_t   bad_cnt_o,
	output logic        seq_err_o
);

	fix_byte_t lane_byte; // shared registered byte.
	logic [`FIX_NUM_LANES-1:0] lane_valid, lane_sof, lane_eof;
	logic [`FIX_NUM_LANES-1:0] lane_res_valid, lane_match, lane_ferr;
	logic [`FIX_NUM_LANES*8-1:0] lane_sum; // 8 bits per lane.
	logic [`FIX_NUM_LANES*24-1:0] lane_calc, lane_rcv; // 24 bits per lane.

	fix_session_demux u_demux (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.sof_i        (sof_i),
		.eof_i        (eof_i),
		.sid_i        (sid_i),
		.lane_byte_o  (lane_byte),
		.lane_valid_o (lane_valid),
		.lane_sof_o   (lane_sof),
		.lane_eof_o   (lane_eof),
		.seq_err_o    (seq_err_o)
	);

	for (genvar g = 0; g < `FIX_NUM_LANES; g++) begin : g_lane
		fix_checksum_lane u_lane (
			.clk          (clk),
			.rst          (rst),
			.byte_i       (lane_byte),
			.valid_i      (lane_valid[g]),
			.sof_i        (lane_sof[g]),
			.eof_i        (lane_eof[g]),
			.res_valid_o  (lane_res_valid[g]),
			.sum_o        (lane_sum[g*8 +: 8]),
			.calc_ascii_o (lane_calc[g*24 +: 24]),
			.rcv_ascii_o  (lane_rcv[g*24 +: 24]),
			.match_o      (lane_match[g]),
			.frame_err_o  (lane_ferr[g])
		);
	end

	fix_result_merge u_merge (
		.clk              (clk),
		.rst              (rst),
		.lane_res_valid_i (lane_res_valid),
		.lane_sum_i       (lane_sum),
		.lane_calc_i      (lane_calc),
		.lane_rcv_i       (lane_rcv),
		.lane_match_i     (lane_match),
		.lane_ferr_i      (lane_ferr),
		.result_valid_o   (result_valid_o),
		.result_sid_o     (result_sid_o),
		.checksum_o       (checksum_o),
		.checksum_ascii_o (checksum_ascii_o),
		.rcv_ascii_o      (rcv_ascii_o),
		.match_o          (match_o),
		.frame_err_o      (frame_err_o),
		.good_cnt_o       (good_cnt_o),
		.bad_cnt_o        (bad_cnt_o)
	);

endmodule

// ==== verif/fix_checksum_tb.sv ====
// testbench for the fix checksum engine.
// seeded random interleaved sessions, reference model, compare tasks and timeouts.
`timescale 1ns/1ps

`include "fix_defines.svh"

module fix_checksum_tb
	import fix_proto_pkg::*;
	import fix_engine_pkg::*;
();

	logic clk, rst;
	fix_byte_t byte_i;
	logic byte_valid_i, sof_i, eof_i;
	sid_t sid_i;
	logic result_valid_o, match_o, frame_err_o, seq_err_o;
	sid_t result_sid_o;
	fix_byte_t checksum_o;
	fix_ascii3_t checksum_ascii_o, rcv_ascii_o;
	stat_cnt_t good_cnt_o, bad_cnt_o;

	int cycle_cnt = 0; // rising edges since time zero.
	string test_name;
	logic [9:0] stream_q [`FIX_NUM_LANES][$]; // {sof, eof, byte} still to send.
	fix_byte_t acc_q [`FIX_NUM_LANES][$]; // model copy of each open message.
	logic [`FIX_NUM_LANES-1:0] open_m; // model of open sessions.
	fix_byte_t msg_buf [$]; // message under construction.
	int exp_cyc [$]; // negedge where each result must show.
	sid_t exp_sid [$];
	fix_byte_t exp_sum [$];
	fix_ascii3_t exp_calc [$], exp_rcv [$];
	logic exp_match [$], exp_ferr [$];
	string exp_name [$];
	int seq_cyc [$]; // negedges where seq_err_o must show.
	stat_cnt_t good_exp, bad_exp;

	fix_checksum_top u_fix_checksum_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic stop_on_error();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(string msg);
		$display("[%s] %s", test_name, msg);
		stop_on_error();
	endtask

	task automatic check_byte(string tname, string what, fix_byte_t exp, fix_byte_t act);
		if (exp !== act) begin
			$display("** Error %s %s expected %0d actual %0d", tname, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_ascii(string tname, string what, fix_ascii3_t exp, fix_ascii3_t act);
		if (exp !== act) begin
			$display("** Error %s %s expected %06h actual %06h", tname, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_flag(string tname, string what, logic exp, logic act);
		if (exp !== act) begin
			$display("** Error %s %s expected %b actual %b", tname, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_cnt(string tname, string what, stat_cnt_t exp, stat_cnt_t act);
		if (exp !== act) begin
			$display("** Error %s %s expected %0d actual %0d", tname, what, exp, act);
			stop_on_error();
		end
	endtask

	// kind 0 good, 1 one digit corrupted, 2 no trailer, 3 two-digit trailer.
	task automatic build_msg(input int kind);
		string head;
		int nf, tag, vlen, pos;
		fix_byte_t sum;
		fix_byte_t dig [3];
		head = "8=FIX";
		msg_buf.delete();
		for (int i = 0; i < head.len(); i++) begin
			msg_buf.push_back(head[i]);
		end
		msg_buf.push_back(FIX_SOH);
		nf = 1 + $urandom % 4;
		for (int f = 0; f < nf; f++) begin
			tag = 11 + $urandom % 89; // never tag 10 in the body.
			msg_buf.push_back(fix_byte_t'(FIX_CHAR_DIGIT0 + tag / 10));
			msg_buf.push_back(fix_byte_t'(FIX_CHAR_DIGIT0 + tag % 10));
			msg_buf.push_back(FIX_CHAR_EQ);
			vlen = 1 + $urandom % 6;
			for (int v = 0; v < vlen; v++) begin
				msg_buf.push_back(fix_byte_t'(8'h21 + $urandom % 94)); // printable, no soh.
			end
			msg_buf.push_back(FIX_SOH);
		end
		if (kind == 2) return;
		sum = '0;
		foreach (msg_buf[i]) sum += msg_buf[i]; // wraps at 256.
		dig[0] = sum / 100;
		dig[1] = (sum / 10) % 10;
		dig[2] = sum % 10;
		if (kind == 1) begin
			pos = $urandom % 3;
			dig[pos] = (dig[pos] + 1 + $urandom % 9) % 10; // always a different digit.
		end
		msg_buf.push_back(FIX_CHAR_ONE);
		msg_buf.push_back(FIX_CHAR_ZERO);
		msg_buf.push_back(FIX_CHAR_EQ);
		for (int d = 0; d < ((kind == 3) ? 2 : 3); d++) begin
			msg_buf.push_back(fix_byte_t'(FIX_CHAR_DIGIT0 + dig[d]));
		end
		msg_buf.push_back(FIX_SOH);
	endtask

	// a restart sends a cut-off message first, then sof again.
	task automatic queue_msg(input int s, input int kind, input bit restart);
		int cut;
		if (restart) begin
			build_msg(2);
			cut = 2 + $urandom % (msg_buf.size() - 2);
			for (int i = 0; i < cut; i++) begin
				stream_q[s].push_back({i == 0, 1'b0, msg_buf[i]});
			end
		end
		build_msg(kind);
		foreach (msg_buf[i]) begin
			stream_q[s].push_back({i == 0, i == msg_buf.size() - 1, msg_buf[i]});
		end
	endtask

	// expected result of a closed message, from the checksum rule.
	task automatic predict(input int s);
		int n, tag_at, val;
		fix_byte_t sum, b;
		fix_ascii3_t rcv, calc;
		logic ferr;
		n = acc_q[s].size();
		tag_at = -1;
		for (int i = 0; i + 3 < n; i++) begin
			if (acc_q[s][i] == FIX_SOH && acc_q[s][i+1] == FIX_CHAR_ONE &&
					acc_q[s][i+2] == FIX_CHAR_ZERO && acc_q[s][i+3] == FIX_CHAR_EQ)
				tag_at = i; // last trailer tag wins.
		end
		sum = '0;
		for (int i = 0; i <= tag_at; i++) sum += acc_q[s][i]; // through the soh before "10=".
		val = sum;
		calc = '0;
		for (int k = 0; k < 3; k++) begin
			calc = {fix_byte_t'(FIX_CHAR_DIGIT0 + val % 10), calc[23:8]}; // ones end at the bottom.
			val = val / 10;
		end
		rcv = '0;
		ferr = (tag_at < 0) || (n - tag_at - 5 != 3) || (acc_q[s][n-1] != FIX_SOH);
		if (!ferr) begin
			for (int j = 0; j < 3; j++) begin
				b = acc_q[s][tag_at+4+j];
				if (b < FIX_CHAR_DIGIT0 || b > FIX_CHAR_DIGIT0 + 8'd9) ferr = 1'b1;
				rcv = {rcv[15:0], b};
			end
		end
		exp_cyc.push_back(cycle_cnt + 4); // sampled 4 edges after the eof byte.
		exp_sid.push_back(sid_t'(s));
		exp_sum.push_back(sum);
		exp_calc.push_back(calc);
		exp_rcv.push_back(rcv);
		exp_match.push_back(!ferr && rcv == calc);
		exp_ferr.push_back(ferr);
		exp_name.push_back(test_name);
		if (!ferr && rcv == calc) good_exp++;
		else bad_exp++;
	endtask

	// session tracking of the model, called when a byte is driven.
	task automatic model_byte(input int s, input logic [9:0] e);
		if (!open_m[s] && !e[9]) begin
			seq_cyc.push_back(cycle_cnt + 1); // orphan, byte dropped.
		end else begin
			if (e[9]) begin
				if (open_m[s]) seq_cyc.push_back(cycle_cnt + 1); // old message abandoned.
				acc_q[s].delete();
				open_m[s] = 1'b1;
			end
			acc_q[s].push_back(e[7:0]);
			if (e[8]) begin
				open_m[s] = 1'b0;
				predict(s);
			end
		end
	endtask

	task automatic drive_entry(input int s, input logic [9:0] e);
		@(negedge clk);
		byte_valid_i = 1'b1;
		sid_i = sid_t'(s);
		sof_i = e[9];
		eof_i = e[8];
		byte_i = e[7:0];
		model_byte(s, e);
	endtask

	task automatic drive_idle();
		@(negedge clk);
		byte_valid_i = 1'b0;
		sof_i = 1'b0;
		eof_i = 1'b0;
		byte_i = fix_byte_t'($urandom); // ignored without valid.
		sid_i = sid_t'($urandom);
	endtask

	function automatic int pending_bytes();
		int n;
		n = 0;
		for (int s = 0; s < `FIX_NUM_LANES; s++) n += stream_q[s].size();
		return n;
	endfunction

	// interleaves the queued sessions byte by byte with random gaps.
	task automatic run_streams();
		int s;
		while (pending_bytes() != 0) begin
			if ($urandom % 5 == 0) begin
				drive_idle();
			end else begin
				s = $urandom % `FIX_NUM_LANES;
				while (stream_q[s].size() == 0) s = (s + 1) % `FIX_NUM_LANES;
				drive_entry(s, stream_q[s].pop_front());
			end
		end
	endtask

	// output monitor, registered outputs are stable at the falling edge.
	task automatic check_outputs();
		int dummy;
		if (seq_err_o === 1'b1) begin
			if (seq_cyc.size() == 0 || seq_cyc[0] != cycle_cnt)
				report_failure("seq_err_o pulsed without a sequencing error");
			dummy = seq_cyc.pop_front();
		end else if (seq_cyc.size() != 0 && seq_cyc[0] <= cycle_cnt) begin
			report_failure("seq_err_o did not pulse after a sequencing error");
		end
		if (result_valid_o === 1'b1) begin
			if (exp_cyc.size() == 0) report_failure("result reported with no message closed");
			if (exp_cyc[0] != cycle_cnt)
				report_failure($sformatf("result at cycle %0d, due at cycle %0d",
					cycle_cnt, exp_cyc[0]));
			check_byte(exp_name[0], "result_sid_o", fix_byte_t'(exp_sid[0]),
				fix_byte_t'(result_sid_o));
			check_flag(exp_name[0], "frame_err_o", exp_ferr[0], frame_err_o);
			check_flag(exp_name[0], "match_o", exp_match[0], match_o);
			if (!exp_ferr[0]) begin
				check_byte(exp_name[0], "checksum_o", exp_sum[0], checksum_o);
				check_ascii(exp_name[0], "checksum_ascii_o", exp_calc[0], checksum_ascii_o);
				check_ascii(exp_name[0], "rcv_ascii_o", exp_rcv[0], rcv_ascii_o);
			end
			dummy = exp_cyc.pop_front();
			void'(exp_sid.pop_front());
			void'(exp_sum.pop_front());
			void'(exp_calc.pop_front());
			void'(exp_rcv.pop_front());
			void'(exp_match.pop_front());
			void'(exp_ferr.pop_front());
			void'(exp_name.pop_front());
		end else if (exp_cyc.size() != 0 && exp_cyc[0] <= cycle_cnt) begin
			report_failure("result_valid_o missing for a closed message");
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (!rst) check_outputs();
		end
	end

	initial begin
		int kind, tmo;
		void'($urandom(32'hdfb1));
		rst = 1'b1;
		byte_i = '0;
		byte_valid_i = 1'b0;
		sof_i = 1'b0;
		eof_i = 1'b0;
		sid_i = '0;
		open_m = '0;
		good_exp = '0;
		bad_exp = '0;
		test_name = "reset";
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag(test_name, "result_valid_o", 1'b0, result_valid_o);
		check_flag(test_name, "seq_err_o", 1'b0, seq_err_o);
		check_cnt(test_name, "good_cnt_o", '0, good_cnt_o);
		check_cnt(test_name, "bad_cnt_o", '0, bad_cnt_o);
		for (int r = 0; r < 80; r++) begin
			test_name = $sformatf("round%0d", r);
			for (int s = 0; s < `FIX_NUM_LANES; s++) begin
				if (r == 0 || $urandom % 4 != 0) begin // round 0 fills every session.
					kind = $urandom % 8;
					kind = (r == 0 || kind < 4) ? 0 : (kind < 6) ? 1 : kind - 4;
					queue_msg(s, kind, r != 0 && $urandom % 8 == 0);
				end
			end
			run_streams();
			if ($urandom % 3 == 0) begin
				test_name = $sformatf("round%0d_orphan", r);
				drive_entry($urandom % `FIX_NUM_LANES, {2'b00, fix_byte_t'($urandom)});
			end
			drive_idle();
		end
		test_name = "drain";
		tmo = 0;
		while (exp_cyc.size() != 0 || seq_cyc.size() != 0) begin
			@(negedge clk);
			tmo++;
			if (tmo > 20) report_failure("timeout waiting for the last results");
		end
		test_name = "counters";
		@(negedge clk);
		check_cnt(test_name, "good_cnt_o", good_exp, good_cnt_o);
		check_cnt(test_name, "bad_cnt_o", bad_exp, bad_cnt_o);
		if (good_exp == 0 || bad_exp == 0) begin
			report_failure("run lacked good or bad messages");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/fix_proto_pkg.sv
rtl/fix_engine_pkg.sv
rtl/fix_session_demux.sv
rtl/fix_checksum_lane.sv
rtl/fix_result_merge.sv
rtl/fix_checksum_top.sv
verif/fix_checksum_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := fix_checksum_tb
RTL_TOP    := fix_checksum_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the simulation output holds the pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
